// File: source/dbus_pkg.sv
`default_nettype none

package dbus_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Bus vector types
    // ~~~~~~~~~~~~~~~~~~~~

    typedef logic [31:0] word_t;       // Data word on the bus
    typedef logic [31:0] addr_t;       // Byte address
    typedef logic [3:0]  byte_en_t;    // Bit n enables byte lane n
    typedef logic [7:0]  uart_byte_t;  // One character on the line
    typedef logic [3:0]  region_t;     // Top address nibble

    // ~~~~~~~~~~~~~~~~~~~~
    // Address map
    // ~~~~~~~~~~~~~~~~~~~~

    localparam region_t REGION_RAM  = 4'h0;
    localparam region_t REGION_UART = 4'hb;

    // Byte offsets inside the UART region
    // Write pushes the low byte, read gives zero
    localparam logic [2:0] UART_REG_DATA   = 3'h0;

    // Read gives {busy, empty, full} in bits 2..0
    localparam logic [2:0] UART_REG_STATUS = 3'h4;

endpackage

`default_nettype wire

// File: source/dbus_decoder.sv
`default_nettype none

module dbus_decoder (
    input  wire                    clk_bus,
    input  wire                    reset_i,
    // Master side
    input  wire dbus_pkg::addr_t   master_address_i,
    input  wire dbus_pkg::byte_en_t master_byteenable_i,
    input  wire                    master_read_i,
    input  wire                    master_write_i,
    input  wire dbus_pkg::word_t   master_wrdata_i,
    output dbus_pkg::word_t        master_rddata_o,
    output logic                   master_stall_o,
    // RAM side
    output dbus_pkg::addr_t        ram_address_o,
    output dbus_pkg::byte_en_t     ram_byteenable_o,
    output logic                   ram_read_o,
    output logic                   ram_write_o,
    output dbus_pkg::word_t        ram_wrdata_o,
    input  wire dbus_pkg::word_t   ram_rddata_i,
    // UART side
    output logic [2:0]             uart_offset_o,
    output logic                   uart_read_o,
    output logic                   uart_write_o,
    output dbus_pkg::word_t        uart_wrdata_o,
    input  wire dbus_pkg::word_t   uart_rddata_i,
    input  wire                    uart_stall_i
);
    import dbus_pkg::*;

    region_t region;
    logic    ram_sel;
    logic    uart_sel;
    logic    rd_wait_q;    // Set for the second cycle of a RAM read

    assign region   = master_address_i[31:28];
    assign ram_sel  = (region == REGION_RAM);
    assign uart_sel = (region == REGION_UART);

    assign ram_address_o    = master_address_i;
    assign ram_byteenable_o = master_byteenable_i;
    assign ram_wrdata_o     = master_wrdata_i;
    assign ram_read_o       = ram_sel && master_read_i;
    assign ram_write_o      = ram_sel && master_write_i;

    assign uart_offset_o = master_address_i[2:0];
    assign uart_wrdata_o = master_wrdata_i;
    assign uart_read_o   = uart_sel && master_read_i;
    assign uart_write_o  = uart_sel && master_write_i;

    // RAM read data is registered, so hold the master one cycle
    always_ff @(posedge clk_bus) begin
        if (reset_i) begin
            rd_wait_q <= 1'b0;
        end else begin
            rd_wait_q <= ram_read_o && !rd_wait_q;
        end
    end

    assign master_stall_o = (ram_read_o && !rd_wait_q) || (uart_sel && uart_stall_i);

    always_comb begin
        master_rddata_o = '0;    // Unmapped reads give zero
        if (ram_sel) begin
            master_rddata_o = ram_rddata_i;
        end else if (uart_sel) begin
            master_rddata_o = uart_rddata_i;
        end
    end

endmodule

`default_nettype wire

// File: source/data_ram.sv
`default_nettype none

module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  wire                     clk_bus,
    input  wire dbus_pkg::addr_t    ram_address_i,
    input  wire dbus_pkg::byte_en_t ram_byteenable_i,
    input  wire                     ram_read_i,
    input  wire                     ram_write_i,
    input  wire dbus_pkg::word_t    ram_wrdata_i,
    output dbus_pkg::word_t         ram_rddata_o
);
    import dbus_pkg::*;

    localparam int IDX_W = $clog2(RAM_WORDS);

    word_t             mem [RAM_WORDS];
    word_t             rddata_q;
    logic [IDX_W-1:0]  word_idx;

    // Word index from the bits above the byte offset
    // Higher address bits alias
    assign word_idx = ram_address_i[IDX_W+1:2];

    // ~~~~~~~~~~~~~~~~~~~~
    // Per-lane write
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_bus) begin
        if (ram_write_i) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (ram_byteenable_i[lane]) begin
                    mem[word_idx][lane*8 +: 8] <= ram_wrdata_i[lane*8 +: 8];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Registered read
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_bus) begin
        if (ram_read_i) begin
            rddata_q <= mem[word_idx];
        end
    end

    assign ram_rddata_o = rddata_q;

endmodule

`default_nettype wire

// File: source/uart_regs.sv
`default_nettype none

module uart_regs (
    input  wire                   clk_bus,
    input  wire                   reset_i,
    // Bus side
    input  wire [2:0]             bus_offset_i,
    input  wire                   bus_read_i,
    input  wire                   bus_write_i,
    input  wire dbus_pkg::word_t  bus_wrdata_i,
    output dbus_pkg::word_t       bus_rddata_o,
    output logic                  bus_stall_o,
    // FIFO and serializer side
    input  wire                   fifo_full_i,
    input  wire                   fifo_empty_i,
    input  wire                   tx_busy_i,
    output logic                  fifo_push_o,
    output dbus_pkg::uart_byte_t  fifo_wdata_o
);
    import dbus_pkg::*;

    logic       data_wr;
    logic       wait_q;    // Previous cycle was a stalled data write
    uart_byte_t hold_q;

    assign data_wr = bus_write_i && (bus_offset_i == UART_REG_DATA);

    // Push when there is room, otherwise hold the master
    assign fifo_push_o = data_wr && !fifo_full_i;
    assign bus_stall_o = data_wr && fifo_full_i;

    // ~~~~~~~~~~~~~~~~~~~~
    // Stalled write byte
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_bus) begin
        if (reset_i) begin
            wait_q <= 1'b0;
        end else begin
            wait_q <= bus_stall_o;
        end
    end

    // Byte taken in the first cycle of the write
    always_ff @(posedge clk_bus) begin
        if (data_wr && !wait_q) begin
            hold_q <= bus_wrdata_i[7:0];
        end
    end

    assign fifo_wdata_o = wait_q ? hold_q : bus_wrdata_i[7:0];

    // Status word, data offset reads as zero
    always_comb begin
        bus_rddata_o = '0;
        if (bus_read_i && (bus_offset_i == UART_REG_STATUS)) begin
            bus_rddata_o[2:0] = {tx_busy_i, fifo_empty_i, fifo_full_i};
        end
    end

endmodule

`default_nettype wire

// File: source/uart_tx_fifo.sv
`default_nettype none

module uart_tx_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire                        clk_bus,
    input  wire                        reset_i,
    input  wire                        push_i,
    input  wire dbus_pkg::uart_byte_t  wdata_i,
    input  wire                        pop_i,
    output dbus_pkg::uart_byte_t       rdata_o,
    output logic                       full_o,
    output logic                       empty_o
);
    import dbus_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    uart_byte_t    mem [FIFO_DEPTH];
    logic [AW:0]   wr_ptr_q;    // Top bit is the wrap flag
    logic [AW:0]   rd_ptr_q;
    logic          do_push;
    logic          do_pop;

    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full_o  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                     (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // ~~~~~~~~~~~~~~~~~~~~
    // Pointers
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_bus) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_bus) begin
        if (do_push) begin
            mem[wr_ptr_q[AW-1:0]] <= wdata_i;
        end
    end

    assign rdata_o = mem[rd_ptr_q[AW-1:0]];    // Oldest byte

endmodule

`default_nettype wire

// File: source/uart_tx.sv
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire                        clk_bus,
    input  wire                        reset_i,
    input  wire                        fifo_empty_i,
    input  wire dbus_pkg::uart_byte_t  fifo_rdata_i,
    output logic                       fifo_pop_o,
    output logic                       busy_o,
    output logic                       txd_o
);
    import dbus_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP
    } tx_state_t;

    tx_state_t        state_q;
    logic [CNT_W-1:0] cnt_q;      // Clocks within the current bit
    logic [2:0]       bit_idx_q;
    uart_byte_t       shift_q;
    logic             bit_end;

    assign bit_end    = (cnt_q == CNT_W'(CLKS_PER_BIT - 1));
    assign fifo_pop_o = (state_q == S_IDLE) && !fifo_empty_i;
    assign busy_o     = (state_q != S_IDLE);

    always_ff @(posedge clk_bus) begin
        if (reset_i) begin
            state_q   <= S_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
        end else begin
            cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
            case (state_q)
                S_IDLE: begin
                    cnt_q <= '0;
                    if (fifo_pop_o) begin
                        shift_q <= fifo_rdata_i;
                        state_q <= S_START;
                    end
                end
                S_START: if (bit_end) begin
                    bit_idx_q <= '0;
                    state_q   <= S_DATA;
                end
                S_DATA: if (bit_end) begin
                    shift_q   <= shift_q >> 1;    // LSB first
                    bit_idx_q <= bit_idx_q + 1'b1;
                    if (bit_idx_q == 3'd7) begin
                        state_q <= S_STOP;
                    end
                end
                S_STOP: if (bit_end) begin
                    state_q <= S_IDLE;    // Look at the FIFO again
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_comb begin
        case (state_q)
            S_START: txd_o = 1'b0;
            S_DATA:  txd_o = shift_q[0];
            default: txd_o = 1'b1;    // Idle and stop are mark
        endcase
    end

endmodule

`default_nettype wire

// File: source/dbus_top.sv
`default_nettype none

module dbus_top #(
    parameter int RAM_WORDS    = 256,
    parameter int FIFO_DEPTH   = 8,
    parameter int CLKS_PER_BIT = 8
) (
    input  wire                     clk_bus,
    input  wire                     reset_i,
    input  wire dbus_pkg::addr_t    bus_address_i,
    input  wire dbus_pkg::byte_en_t bus_byteenable_i,
    input  wire                     bus_read_i,
    input  wire                     bus_write_i,
    input  wire dbus_pkg::word_t    bus_wrdata_i,
    output dbus_pkg::word_t         bus_rddata_o,
    output logic                    bus_stall_o,
    output logic                    txd_o
);

    dbus_pkg::addr_t      ram_address;
    dbus_pkg::byte_en_t   ram_byteenable;
    dbus_pkg::word_t      ram_wrdata;
    dbus_pkg::word_t      ram_rddata;
    logic                 ram_read;
    logic                 ram_write;

    logic [2:0]           uart_offset;
    dbus_pkg::word_t      uart_wrdata;
    dbus_pkg::word_t      uart_rddata;
    logic                 uart_read;
    logic                 uart_write;
    logic                 uart_stall;

    dbus_pkg::uart_byte_t fifo_wdata;
    dbus_pkg::uart_byte_t fifo_rdata;
    logic                 fifo_push;
    logic                 fifo_pop;
    logic                 fifo_full;
    logic                 fifo_empty;
    logic                 tx_busy;

    dbus_decoder dbus_decoder_inst (
        .clk_bus            (clk_bus),
        .reset_i            (reset_i),
        .master_address_i   (bus_address_i),
        .master_byteenable_i(bus_byteenable_i),
        .master_read_i      (bus_read_i),
        .master_write_i     (bus_write_i),
        .master_wrdata_i    (bus_wrdata_i),
        .master_rddata_o    (bus_rddata_o),
        .master_stall_o     (bus_stall_o),
        .ram_address_o      (ram_address),
        .ram_byteenable_o   (ram_byteenable),
        .ram_read_o         (ram_read),
        .ram_write_o        (ram_write),
        .ram_wrdata_o       (ram_wrdata),
        .ram_rddata_i       (ram_rddata),
        .uart_offset_o      (uart_offset),
        .uart_read_o        (uart_read),
        .uart_write_o       (uart_write),
        .uart_wrdata_o      (uart_wrdata),
        .uart_rddata_i      (uart_rddata),
        .uart_stall_i       (uart_stall)
    );

    data_ram #(.RAM_WORDS(RAM_WORDS)) data_ram_inst (
        .clk_bus         (clk_bus),
        .ram_address_i   (ram_address),
        .ram_byteenable_i(ram_byteenable),
        .ram_read_i      (ram_read),
        .ram_write_i     (ram_write),
        .ram_wrdata_i    (ram_wrdata),
        .ram_rddata_o    (ram_rddata)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // UART transmit chain
    // ~~~~~~~~~~~~~~~~~~~~
    uart_regs uart_regs_inst (
        .clk_bus     (clk_bus),
        .reset_i     (reset_i),
        .bus_offset_i(uart_offset),
        .bus_read_i  (uart_read),
        .bus_write_i (uart_write),
        .bus_wrdata_i(uart_wrdata),
        .bus_rddata_o(uart_rddata),
        .bus_stall_o (uart_stall),
        .fifo_full_i (fifo_full),
        .fifo_empty_i(fifo_empty),
        .tx_busy_i   (tx_busy),
        .fifo_push_o (fifo_push),
        .fifo_wdata_o(fifo_wdata)
    );

    uart_tx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) uart_tx_fifo_inst (
        .clk_bus(clk_bus),
        .reset_i(reset_i),
        .push_i (fifo_push),
        .wdata_i(fifo_wdata),
        .pop_i  (fifo_pop),
        .rdata_o(fifo_rdata),
        .full_o (fifo_full),
        .empty_o(fifo_empty)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_inst (
        .clk_bus     (clk_bus),
        .reset_i     (reset_i),
        .fifo_empty_i(fifo_empty),
        .fifo_rdata_i(fifo_rdata),
        .fifo_pop_o  (fifo_pop),
        .busy_o      (tx_busy),
        .txd_o       (txd_o)
    );

endmodule

`default_nettype wire

// File: dv/dbus_tb.sv
`default_nettype none

module dbus_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int CLKS_PER_BIT = 4;
    localparam int RAM_WORDS    = 256;
    localparam int N_RAM        = 24;
    localparam int N_UNMAP      = 4;
    localparam int N_CHARS      = 4;
    localparam int N_BURST      = 12;    // More than FIFO depth plus one
    localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT + 2;
    localparam int BUS_OPS      = 4 * N_RAM + 3 * N_UNMAP + N_CHARS + N_BURST + 8;
    localparam int TIMEOUT      = 2 * CLK_PERIOD *
                                  (4 * BUS_OPS + (N_CHARS + N_BURST + 2) * FRAME_CLKS);

    localparam logic [31:0] UART_DATA   = 32'hb000_0000;
    localparam logic [31:0] UART_STATUS = 32'hb000_0004;
    localparam logic [31:0] IDLE_STATUS = 32'h0000_0002;    // Empty only

    logic        clk_bus = 1'b0;
    logic        reset;
    logic [31:0] bus_address;
    logic [3:0]  bus_byteenable;
    logic        bus_read;
    logic        bus_write;
    logic [31:0] bus_wrdata;
    logic [31:0] bus_rddata;
    logic        bus_stall;
    logic        txd;

    logic [31:0] lfsr_state;
    logic [31:0] ram_shadow [RAM_WORDS];
    logic [7:0]  used_idx [N_RAM];
    logic [7:0]  exp_q [$];
    int          stall_count = 0;

    always #(CLK_PERIOD / 2) clk_bus = ~clk_bus;

    dbus_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) dbus_top_inst (
        .clk_bus         (clk_bus),
        .reset_i         (reset),
        .bus_address_i   (bus_address),
        .bus_byteenable_i(bus_byteenable),
        .bus_read_i      (bus_read),
        .bus_write_i     (bus_write),
        .bus_wrdata_i    (bus_wrdata),
        .bus_rddata_o    (bus_rddata),
        .bus_stall_o     (bus_stall),
        .txd_o           (txd)
    );

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp_val);
        assert (got === exp_val)
        else report_error($sformatf("Error: %s = 0x%08h, expected 0x%08h", name, got, exp_val));
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Bus master
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic bus_access(input logic is_write, input logic [31:0] addr,
                              input logic [3:0] be, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        bus_address    = addr;
        bus_byteenable = be;
        bus_wrdata     = wdata;
        bus_read       = !is_write;
        bus_write      = is_write;
        @(negedge clk_bus);
        while (bus_stall) begin
            stall_count++;
            @(negedge clk_bus);
        end
        rdata = bus_rddata;    // Access ends at the next rising edge
        @(posedge clk_bus);
        #1;
        bus_read  = 1'b0;
        bus_write = 1'b0;
    endtask

    task automatic ram_write(input logic [7:0] idx, input logic [3:0] be,
                             input logic [31:0] data);
        logic [31:0] r;
        logic [31:0] rd;
        for (int lane = 0; lane < 4; lane++) begin
            if (be[lane]) begin
                ram_shadow[idx][lane*8 +: 8] = data[lane*8 +: 8];
            end
        end
        r = rand_bits(18);    // Alias bits above the RAM size
        bus_access(1'b1, {4'h0, r[17:0], idx, 2'b00}, be, data, rd);
    endtask

    task automatic ram_check(input logic [7:0] idx);
        logic [31:0] r;
        logic [31:0] rd;
        r = rand_bits(18);
        bus_access(1'b0, {4'h0, r[17:0], idx, 2'b00}, 4'hf, 32'h0, rd);
        check_value("bus_rddata_o", rd, ram_shadow[idx]);
    endtask

    task automatic read_status(output logic [31:0] st);
        bus_access(1'b0, UART_STATUS, 4'hf, 32'h0, st);
    endtask

    task automatic send_char(input logic [7:0] ch);
        logic [31:0] rd;
        exp_q.push_back(ch);
        bus_access(1'b1, UART_DATA, 4'h1, {24'h0, ch}, rd);
    endtask

    // Poll until FIFO empty, serializer idle and every byte seen
    task automatic wait_tx_idle();
        logic [31:0] st;
        read_status(st);
        while (!(st[1] && !st[2] && exp_q.size() == 0)) begin
            read_status(st);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Protocol checks
    // ~~~~~~~~~~~~~~~~~~~~
    no_stall_when_idle: assert property (@(negedge clk_bus) disable iff (reset)
        !(bus_read || bus_write) |-> !bus_stall)
        else report_error("bus_stall_o was high with no request on the bus");

    no_stall_fast_path: assert property (@(negedge clk_bus) disable iff (reset)
        (bus_write && bus_address[31:28] == 4'h0) ||
        ((bus_read || bus_write) && bus_address[31:28] != 4'h0 &&
         bus_address[31:28] != 4'hb) |-> !bus_stall)
        else report_error("bus_stall_o was high on a RAM write or an unmapped access");

    initial begin : serial_monitor
        logic [7:0] rx;
        logic [7:0] exp_byte;
        forever begin
            @(negedge clk_bus);
            if (!reset && txd === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge clk_bus);    // Middle of start bit
                check_value("txd_o start bit", {31'b0, txd}, 32'h0);
                for (int b = 0; b < 8; b++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk_bus);
                    rx[b] = txd;
                end
                repeat (CLKS_PER_BIT) @(negedge clk_bus);
                check_value("txd_o stop bit", {31'b0, txd}, 32'h1);
                assert (exp_q.size() != 0)
                else report_error("A frame arrived on txd_o with no byte pending");
                exp_byte = exp_q.pop_front();
                check_value("txd_o frame byte", {24'b0, rx}, {24'b0, exp_byte});
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT);
        report_error("The run timed out before all tests completed");
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~
    initial begin : main_seq
        logic [31:0] r;
        logic [31:0] rd;
        logic [31:0] st;
        logic [31:0] addr;
        logic [3:0]  region;
        reset          = 1'b1;
        bus_address    = '0;
        bus_byteenable = '0;
        bus_read       = 1'b0;
        bus_write      = 1'b0;
        bus_wrdata     = '0;
        lfsr_state     = 32'hba1a072e;
        repeat (2) @(posedge clk_bus);
        #1;
        reset = 1'b0;

        @(negedge clk_bus);
        check_value("txd_o", {31'b0, txd}, 32'h1);
        check_value("bus_stall_o", {31'b0, bus_stall}, 32'h0);
        @(posedge clk_bus);
        #1;
        read_status(st);
        check_value("bus_rddata_o (status)", st, IDLE_STATUS);

        // Full word first so no lane is left unknown
        for (int i = 0; i < N_RAM; i++) begin
            r           = rand_bits(8);
            used_idx[i] = r[7:0];
            ram_write(used_idx[i], 4'hf, rand_bits(32));
            r = rand_bits(4);
            ram_write(used_idx[i], r[3:0], rand_bits(32));
        end
        for (int i = 0; i < N_RAM; i++) begin
            ram_check(used_idx[i]);
        end

        for (int i = 0; i < N_UNMAP; i++) begin
            r      = rand_bits(4);
            region = r[3:0];
            if (region == 4'h0 || region == 4'hb) begin
                region = 4'h7;
            end
            addr = {region, 18'h0, used_idx[i], 2'b00};
            bus_access(1'b1, addr, 4'hf, rand_bits(32), rd);
            bus_access(1'b0, addr, 4'hf, 32'h0, rd);
            check_value("bus_rddata_o (unmapped)", rd, 32'h0);
            ram_check(used_idx[i]);    // RAM word untouched
        end

        for (int i = 0; i < N_CHARS; i++) begin
            r = rand_bits(8);
            send_char(r[7:0]);
        end
        wait_tx_idle();

        stall_count = 0;
        for (int i = 0; i < N_BURST; i++) begin
            r = rand_bits(8);
            send_char(r[7:0]);
        end
        read_status(st);
        check_value("bus_rddata_o[0] (fifo full)", {31'b0, st[0]}, 32'h1);
        assert (stall_count > 0)
        else report_error("bus_stall_o never rose during the UART burst");

        wait_tx_idle();
        read_status(st);
        check_value("bus_rddata_o (status)", st, IDLE_STATUS);
        repeat (2 * CLKS_PER_BIT) begin
            @(negedge clk_bus);
            check_value("txd_o", {31'b0, txd}, 32'h1);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
source/dbus_pkg.sv
source/dbus_decoder.sv
source/data_ram.sv
source/uart_regs.sv
source/uart_tx_fifo.sv
source/uart_tx.sv
source/dbus_top.sv
dv/dbus_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the data-bus testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --assert --top-module dbus_tb -f sources.f -o dbus_sim \
    && ./obj_dir/dbus_sim 2>&1 | tee sim.log \
    ; grep -q "Simulation finished: PASS" sim.log \
    && echo "Test run passed" \
    || { echo "Test run failed"; exit 1; }
